//--- run.sh
#!/bin/sh
verilator --binary --timing --assert --top-module cpuTb -f src.f -o cpuSim || exit 1
./obj_dir/cpuSim > sim.log 2>&1
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1
grep -q "PASS: all tests" sim.log && exit 0 || exit 1

//--- source/alu.sv
module alu (
   input  opcodes::alu_functions_t  Function,
   input  cpuTypes::word_t          A,
   input  cpuTypes::word_t          B,
   input  logic                     CarryIn,
   output cpuTypes::word_t          Result,
   output cpuTypes::flags_t         FlagsOut
);

   logic [16:0] sum;
   logic        carryTerm;

   always_comb begin
      carryTerm = (Function == opcodes::FnADC) ? CarryIn : 1'b0;
      sum = {1'b0, A} + {1'b0, B} + {16'h0000, carryTerm};
      if (Function == opcodes::FnNOP) begin
         Result = A;
         FlagsOut.carry = CarryIn;      // Carry passes through
         FlagsOut.overflow = 1'b0;
      end else begin
         Result = sum[15:0];
         FlagsOut.carry = sum[16];
         // Same-sign operands giving an opposite-sign result
         FlagsOut.overflow = (A[15] == B[15]) && (sum[15] != A[15]);
      end
      FlagsOut.zero = (Result == 16'h0000);
      FlagsOut.negative = Result[15];
   end

endmodule

//--- source/control.sv
module control (
   input  logic               Clock,
   input  logic               nReset,
   input  opcodes::Opcode_t   Opcode,
   input  cpuTypes::flags_t   Flags,
   controlBus.sequencer       ctl,
   output logic               ALE,
   output logic               nME,
   output logic               nOE,
   output logic               nWE,
   output logic               ENB
);

   enum logic {fetch, execute} state;
   enum logic [1:0] {fet1, fet2, fet3, fet4} fetchSub;
   enum logic {exe1, exe2} executeSub;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         state <= fetch;
         fetchSub <= fet1;
         executeSub <= exe1;
      end else if (state == fetch) begin
         case (fetchSub)
            fet1: fetchSub <= fet2;
            fet2: fetchSub <= fet3;
            fet3: fetchSub <= fet4;
            default: begin
               state <= execute;
               fetchSub <= fet1;
               executeSub <= exe1;
            end
         endcase
      end else begin
         if (executeSub == exe1 && Opcode == opcodes::ST)
            executeSub <= exe2;   // Store needs a write cycle
         else begin
            state <= fetch;
            executeSub <= exe1;
         end
      end
   end

   always_comb begin
      ctl.AluOp   = opcodes::FnNOP;
      ctl.Op1Sel  = opcodes::Op1Rd1;
      ctl.Op2Sel  = 1'b0;
      ctl.ImmSel  = 1'b0;
      ctl.Rs1Sel  = 1'b0;
      ctl.RegWe   = 1'b0;
      ctl.PcWe    = 1'b0;
      ctl.PcSel   = opcodes::PcHold;
      ctl.PcEn    = 1'b0;
      ctl.IrWe    = 1'b0;
      ctl.AddrSel = 1'b0;
      ctl.WdEn    = 1'b0;
      ALE = 1'b0;
      nME = 1'b1;
      nOE = 1'b1;
      nWE = 1'b1;
      ENB = 1'b0;
      if (state == fetch) begin
         case (fetchSub)
            fet1: begin
               ALE = 1'b1;
               ctl.PcEn = 1'b1;
            end
            fet2: begin
               nME = 1'b0;
               nOE = 1'b0;
            end
            fet3: begin
               nME = 1'b0;
               nOE = 1'b0;
               ENB = 1'b1;
            end
            default: begin
               nME = 1'b0;
               nOE = 1'b0;
               ctl.IrWe = 1'b1;
            end
         endcase
      end else if (executeSub == exe1) begin
         if (Opcode == opcodes::ST) begin
            ALE = 1'b1;          // rs value out as address
            ctl.AddrSel = 1'b1;
         end else begin
            ctl.PcEn = 1'b1;
            ctl.PcWe = 1'b1;
            ctl.PcSel = opcodes::Pc1;
            ctl.Rs1Sel = 1'b1;
            case (Opcode)
               opcodes::ADD: begin
                  ctl.AluOp = opcodes::FnADD;
                  ctl.Op2Sel = 1'b1;
                  ctl.RegWe = 1'b1;
               end
               opcodes::ADDI: begin
                  ctl.AluOp = opcodes::FnADD;
                  ctl.RegWe = 1'b1;
               end
               opcodes::ADDIB: begin
                  ctl.AluOp = opcodes::FnADD;
                  ctl.ImmSel = 1'b1;
                  ctl.RegWe = 1'b1;
               end
               opcodes::ADC: begin
                  ctl.AluOp = Flags.carry ? opcodes::FnADC : opcodes::FnADD;
                  ctl.Op2Sel = 1'b1;
                  ctl.RegWe = 1'b1;
               end
               opcodes::ADCI: begin
                  ctl.AluOp = Flags.carry ? opcodes::FnADC : opcodes::FnADD;
                  ctl.RegWe = 1'b1;
               end
               default: ;           // Unknown opcode, PC step only
            endcase
         end
      end else begin
         nME = 1'b0;                // Store write cycle
         nWE = 1'b0;
         ENB = 1'b1;
         ctl.WdEn = 1'b1;
         ctl.PcWe = 1'b1;
         ctl.PcSel = opcodes::Pc1;
      end
   end

endmodule

//--- source/controlBus.sv
interface controlBus;

   opcodes::alu_functions_t AluOp;
   opcodes::Op1_select_t    Op1Sel;
   logic                    Op2Sel;     // High for register, low for immediate
   logic                    ImmSel;     // Upper byte immediate
   logic                    Rs1Sel;     // Read port 1 takes rd
   logic                    RegWe;
   logic                    PcWe;
   opcodes::pc_select_t     PcSel;
   logic                    PcEn;       // PC onto the address bus
   logic                    IrWe;
   logic                    AddrSel;    // rs register as address
   logic                    WdEn;

   modport sequencer (
      output AluOp, Op1Sel, Op2Sel, ImmSel, Rs1Sel, RegWe,
      output PcWe, PcSel, PcEn, IrWe, AddrSel, WdEn
   );

   modport datapath (
      input AluOp, Op1Sel, Op2Sel, ImmSel, Rs1Sel, RegWe,
      input PcWe, PcSel, PcEn, IrWe, AddrSel, WdEn
   );

endinterface

//--- source/cpu.sv
module cpu #(
   parameter cpuTypes::word_t ResetVector = 16'h0000
) (
   input  logic               Clock,
   input  logic               nReset,
   input  cpuTypes::word_t    ReadData,
   output cpuTypes::word_t    Address,
   output cpuTypes::word_t    WriteData,
   output logic               ALE,
   output logic               nME,
   output logic               nOE,
   output logic               nWE,
   output logic               ENB
);

   opcodes::Opcode_t opcode;
   cpuTypes::flags_t flags;

   controlBus ctlBus ();

   control sequencer (
      .Clock  (Clock),
      .nReset (nReset),
      .Opcode (opcode),
      .Flags  (flags),
      .ctl    (ctlBus.sequencer),
      .ALE    (ALE),
      .nME    (nME),
      .nOE    (nOE),
      .nWE    (nWE),
      .ENB    (ENB)
   );

   datapath #(.ResetVector(ResetVector)) path (
      .Clock     (Clock),
      .nReset    (nReset),
      .ctl       (ctlBus.datapath),
      .ReadData  (ReadData),
      .Address   (Address),
      .WriteData (WriteData),
      .Opcode    (opcode),
      .Flags     (flags)
   );

endmodule

//--- source/cpuTypes.sv
package cpuTypes;

   typedef logic [15:0] word_t;
   typedef logic [2:0]  regIndex_t;

   typedef struct packed {
      logic carry;
      logic zero;
      logic negative;
      logic overflow;
   } flags_t;

   // Same word, decoded as register or immediate form
   typedef union packed {
      struct packed {
         logic [4:0] opcode;
         regIndex_t  rd;
         regIndex_t  rs;
         logic [4:0] spare;
      } regForm;
      struct packed {
         logic [4:0] opcode;
         regIndex_t  rd;
         logic [7:0] imm;
      } immForm;
   } instruction_t;

endpackage

//--- source/datapath.sv
module datapath #(
   parameter cpuTypes::word_t ResetVector = 16'h0000
) (
   input  logic               Clock,
   input  logic               nReset,
   controlBus.datapath        ctl,
   input  cpuTypes::word_t    ReadData,
   output cpuTypes::word_t    Address,
   output cpuTypes::word_t    WriteData,
   output opcodes::Opcode_t   Opcode,
   output cpuTypes::flags_t   Flags
);

   cpuTypes::word_t        regs [8];
   cpuTypes::word_t        pc;
   cpuTypes::instruction_t ir;
   cpuTypes::regIndex_t    rd;
   cpuTypes::regIndex_t    rs;
   cpuTypes::regIndex_t    rs1Index;
   cpuTypes::word_t        rd1;
   cpuTypes::word_t        rd2;
   cpuTypes::word_t        imm;
   cpuTypes::word_t        opA;
   cpuTypes::word_t        opB;
   cpuTypes::word_t        aluResult;
   cpuTypes::flags_t       aluFlags;

   assign rd = ir.regForm.rd;
   assign rs = ir.regForm.rs;
   assign Opcode = opcodes::Opcode_t'(ir.regForm.opcode);

   assign rs1Index = ctl.Rs1Sel ? rd : rs;
   assign rd1 = regs[rs1Index];
   assign rd2 = regs[rs];

   // Upper byte or sign extended
   assign imm = ctl.ImmSel ? {ir.immForm.imm, 8'h00}
                           : {{8{ir.immForm.imm[7]}}, ir.immForm.imm};

   assign opA = (ctl.Op1Sel == opcodes::Op1Pc) ? pc : rd1;
   assign opB = ctl.Op2Sel ? rd2 : imm;

   alu adder (
      .Function (ctl.AluOp),
      .A        (opA),
      .B        (opB),
      .CarryIn  (Flags.carry),
      .Result   (aluResult),
      .FlagsOut (aluFlags)
   );

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         for (int i = 0; i < 8; i++)
            regs[i] <= '0;
         Flags <= '0;
      end else if (ctl.RegWe) begin
         regs[rd] <= aluResult;
         Flags <= aluFlags;
      end
   end

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         pc <= ResetVector;
         ir <= '0;
      end else begin
         if (ctl.PcWe)
            pc <= (ctl.PcSel == opcodes::Pc1) ? pc + 16'd1 : pc;
         if (ctl.IrWe)
            ir <= ReadData;   // End of fet4
      end
   end

   assign Address = ctl.AddrSel ? rd1 : (ctl.PcEn ? pc : '0);
   assign WriteData = ctl.WdEn ? regs[rd] : '0;

endmodule

//--- source/opcodes.sv
package opcodes;

   // Instruction opcodes, top five bits of the instruction word
   typedef enum logic [4:0] {
      ADD   = 5'h01,    // rd = rd + rs
      ADDI  = 5'h02,    // rd = rd + sext(imm)
      ADDIB = 5'h03,    // rd = rd + {imm, 8'h00}
      ADC   = 5'h04,    // rd = rd + rs + carry
      ADCI  = 5'h05,    // rd = rd + sext(imm) + carry
      ST    = 5'h06     // mem[rs] = rd
   } Opcode_t;

   // ALU function select
   typedef enum logic [1:0] {
      FnNOP = 2'b00,
      FnADD = 2'b01,
      FnADC = 2'b10
   } alu_functions_t;

   // First ALU operand
   typedef enum logic {
      Op1Rd1 = 1'b0,    // Register read port 1
      Op1Pc  = 1'b1
   } Op1_select_t;

   // Next program counter
   typedef enum logic {
      Pc1    = 1'b0,
      PcHold = 1'b1
   } pc_select_t;

endpackage

//--- src.f
source/opcodes.sv
source/cpuTypes.sv
source/controlBus.sv
source/control.sv
source/alu.sv
source/datapath.sv
source/cpu.sv
test/cpu_assertions.sv
test/cpuTb.sv

//--- test/cpuTb.sv
module cpuTb;

   localparam cpuTypes::word_t ResetVector = 16'h0010;
   localparam int TimeoutCycles = (5 + 7 + 5 + 8 + 42) * 6 + 50;  // Instructions plus next fetch

   logic Clock;
   logic nReset = 1'b0;
   logic ALE, nME, nOE, nWE, ENB;
   cpuTypes::word_t ReadData = '0;
   cpuTypes::word_t Address, WriteData, latchAddr;
   cpuTypes::word_t mem [256];
   cpuTypes::word_t model [8];                  // Reference registers
   cpuTypes::word_t writeAddr [$], writeData [$], expAddr [$], expData [$];
   logic carry;
   logic fetchPending = 1'b0;
   int progLen, logBase, fetchBase, errors;
   int fetchCount = 0;
   int cycles = 0;
   logic [31:0] rngState = 32'h4133;

   cpu #(.ResetVector(ResetVector)) dut (.*);

   initial begin
      Clock = 1'b0;
      forever #50 Clock = ~Clock;
   end

   always @(posedge Clock) begin
      cycles++;
      if (cycles >= TimeoutCycles) begin
         $display("Timeout: the processor stopped making progress after %0d cycles", cycles);
         $display("FAIL: see errors above");
         $fatal(1, "timeout");
      end
   end

   // Memory model, address latched on ALE
   always @(posedge Clock) begin
      if (ALE) begin
         latchAddr = Address;
         fetchPending = 1'b1;
      end else if (!nWE && !nME) begin
         writeAddr.push_back(latchAddr);
         writeData.push_back(WriteData);
         fetchPending = 1'b0;                   // Store cycle, not a fetch
      end else if (!nOE && !nME && fetchPending) begin
         fetchCount++;
         fetchPending = 1'b0;
      end
   end

   always @(negedge Clock)
      if (!nOE && !nME)
         ReadData <= mem[latchAddr[7:0]];

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   task automatic checkWord(string name, cpuTypes::word_t actual, cpuTypes::word_t expected);
      if (actual !== expected) begin
         errors++;
         $display("Mismatch at %0t: %s actual %h expected %h", $time, name, actual, expected);
         $display("FAIL: see errors above");
         $fatal(1, "word check");
      end
   endtask

   task automatic checkStrobe(string name, logic actual, logic expected);
      if (actual !== expected) begin
         errors++;
         $display("Mismatch at %0t: %s actual %b expected %b", $time, name, actual, expected);
         $display("FAIL: see errors above");
         $fatal(1, "strobe check");
      end
   endtask

   // Places one instruction and steps the reference model
   task automatic emit(opcodes::Opcode_t op, cpuTypes::regIndex_t rd, cpuTypes::regIndex_t rs,
                       logic [7:0] imm);
      cpuTypes::instruction_t ins;
      cpuTypes::word_t b;
      logic [16:0] sum;
      ins.immForm.opcode = op;
      ins.immForm.rd = rd;
      ins.immForm.imm = imm;
      if (op inside {opcodes::ADD, opcodes::ADC, opcodes::ST}) begin
         ins.regForm.rs = rs;
         ins.regForm.spare = '0;
      end
      case (op)
         opcodes::ADD, opcodes::ADC: b = model[rs];
         opcodes::ADDIB: b = {imm, 8'h00};
         default: b = {{8{imm[7]}}, imm};
      endcase
      if (op == opcodes::ST) begin
         expAddr.push_back(model[rs]);
         expData.push_back(model[rd]);
      end else begin
         sum = {1'b0, model[rd]} + {1'b0, b};
         if ((op == opcodes::ADC || op == opcodes::ADCI) && carry)
            sum = sum + 17'd1;
         model[rd] = sum[15:0];
         carry = sum[16];
      end
      mem[8'(int'(ResetVector) + progLen)] = ins;
      progLen++;
   endtask

   task automatic beginTest();
      @(negedge Clock);
      nReset = 1'b0;
      for (int a = 0; a < 256; a++)
         mem[8'(a)] = {5'h1F, 3'b000, 8'(a)};   // Unknown opcode, tagged by address
      for (int r = 0; r < 8; r++)
         model[r] = '0;
      carry = 1'b0;
      expAddr.delete();
      expData.delete();
      progLen = 0;
   endtask

   task automatic releaseReset();
      repeat (2) @(negedge Clock);
      nReset = 1'b1;
      fetchBase = fetchCount;
      logBase = writeAddr.size();
   endtask

   task automatic runAndCheck();
      releaseReset();
      while (fetchCount - fetchBase < progLen + 1)
         @(negedge Clock);
      checkWord("store count", cpuTypes::word_t'(writeAddr.size() - logBase),
                cpuTypes::word_t'(expAddr.size()));
      foreach (expAddr[i]) begin
         checkWord("store address", writeAddr[logBase + i], expAddr[i]);
         checkWord("store data", writeData[logBase + i], expData[i]);
      end
   endtask

   task automatic resetAndFetch();
      int cyc;
      int last;
      int k;
      beginTest();
      releaseReset();
      #1;
      checkStrobe("ALE", ALE, 1'b1);
      checkWord("Address", Address, ResetVector);
      cyc = 0;
      last = 0;
      k = 1;
      while (k < 5) begin
         @(negedge Clock);
         cyc++;
         checkStrobe("nWE", nWE, 1'b1);
         checkStrobe("ENB", ENB, (cyc - last) == 2);   // Data enable in third fetch cycle
         if (ALE) begin
            checkWord("Address", Address, ResetVector + cpuTypes::word_t'(k));
            checkWord("ALE spacing", cpuTypes::word_t'(cyc - last), 16'd5);
            last = cyc;
            k++;
         end
      end
   endtask

   task automatic addAndAddi();
      beginTest();
      emit(opcodes::ADDI, 1, 0, 8'h21);
      emit(opcodes::ADDI, 2, 0, 8'h13);
      emit(opcodes::ADD, 1, 2, 8'h00);
      emit(opcodes::ADDI, 3, 0, 8'h40);
      emit(opcodes::ST, 1, 3, 8'h00);
      emit(opcodes::ST, 2, 3, 8'h00);
      runAndCheck();
   endtask

   task automatic addUpperByte();
      beginTest();
      emit(opcodes::ADDI, 1, 0, 8'h34);
      emit(opcodes::ADDIB, 1, 0, 8'h12);
      emit(opcodes::ADDI, 5, 0, 8'h50);
      emit(opcodes::ST, 1, 5, 8'h00);
      runAndCheck();
      checkWord("ADDIB word", writeData[logBase], 16'h1234);
   endtask

   task automatic carryChain();
      beginTest();
      emit(opcodes::ADDI, 3, 0, 8'h70);
      emit(opcodes::ADDI, 1, 0, 8'hFF);        // 16'hFFFF
      emit(opcodes::ADDI, 1, 0, 8'h01);        // Carry set
      emit(opcodes::ADCI, 2, 0, 8'h05);
      emit(opcodes::ST, 2, 3, 8'h00);
      emit(opcodes::ADC, 4, 2, 8'h00);         // Carry now clear
      emit(opcodes::ST, 4, 3, 8'h00);
      runAndCheck();
      checkWord("ADCI sum", writeData[logBase], 16'h0006);
      checkWord("ADC sum", writeData[logBase + 1], 16'h0006);
   endtask

   task automatic randomSequence();
      cpuTypes::regIndex_t rd;
      cpuTypes::regIndex_t rs;
      beginTest();
      emit(opcodes::ADDI, 7, 0, 8'h60);        // Fixed store address
      for (int n = 0; n < 20; n++) begin
         rngState = xorshift(rngState);
         rd = rngState[10:8] % 3'd7;
         rs = rngState[13:11] % 3'd7;
         case (rngState[1:0])
            2'd0: emit(opcodes::ADDI, rd, 0, rngState[23:16]);
            2'd1: emit(opcodes::ADD, rd, rs, 8'h00);
            default: emit(opcodes::ADC, rd, rs, 8'h00);
         endcase
         emit(opcodes::ST, rd, 7, 8'h00);
      end
      runAndCheck();
   endtask

   initial begin
      errors = 0;
      resetAndFetch();
      addAndAddi();
      addUpperByte();
      carryChain();
      randomSequence();
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

//--- test/cpu_assertions.sv
module cpu_assertions (
   input logic Clock,
   input logic nReset,
   input logic ALE,
   input logic nME,
   input logic nOE,
   input logic nWE
);

   logic [2:0] sinceAle;   // Cycles since the last ALE

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset)
         sinceAle <= '0;
      else if (ALE)
         sinceAle <= '0;
      else
         sinceAle <= sinceAle + 3'd1;
   end

   writeInsideMemCycle: assert property (@(posedge Clock) disable iff (!nReset) !nWE |-> !nME)
      else $error("nWE low while nME high");

   aleNotWithOe: assert property (@(posedge Clock) disable iff (!nReset) !(ALE && !nOE))
      else $error("ALE and nOE active together");

   aleEverySix: assert property (@(posedge Clock) disable iff (!nReset) ALE || sinceAle < 3'd5)
      else $error("No ALE within six cycles");

endmodule

bind cpu cpu_assertions busChecks (
   .Clock  (Clock),
   .nReset (nReset),
   .ALE    (ALE),
   .nME    (nME),
   .nOE    (nOE),
   .nWE    (nWE)
);
